// File: vmpeg_pkg.sv
package vmpeg_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 15;   // Word address, bus bits 15 to 1

    typedef logic [DATA_W-1:0] word_t;

    // Host visible registers by word address
    typedef enum logic [ADDR_W-1:0] {
        REG_FMA_CMD    = 15'h1800,
        REG_FMA_STAT   = 15'h1801,
        REG_FMA_IVEC   = 15'h1806,
        REG_FMA_DCLKH  = 15'h1808,
        REG_FMA_DCLKL  = 15'h1809,
        REG_FMA_ISR    = 15'h180D,
        REG_FMA_IER    = 15'h180E,
        REG_FMV_IER    = 15'h2030,
        REG_FMV_ISR    = 15'h2031,
        REG_FMV_TCNT   = 15'h2032,
        REG_FMV_TRLD   = 15'h2057,
        REG_FMV_SYSCMD = 15'h2060,
        REG_FMV_IVEC   = 15'h206E,
        REG_FMV_XFER   = 15'h206F
    } reg_addr_e;

    typedef enum logic {
        CHAN_FMA = 1'b0,
        CHAN_FMV = 1'b1
    } chan_e;

    localparam int NUM_CHAN = 2;

    // FMA ISR and STAT bits
    localparam int FMA_UPD  = 2;
    localparam int FMA_UNF  = 3;
    localparam int FMA_DEC  = 4;
    localparam int FMA_POLL = 8;

    // FMV ISR bits
    localparam int FMV_SEQ   = 0;
    localparam int FMV_GOP   = 1;
    localparam int FMV_PIC   = 2;
    localparam int FMV_EOD   = 3;
    localparam int FMV_NDAT  = 5;
    localparam int FMV_TIM   = 8;
    localparam int FMV_VSYNC = 11;

    // Command register bits
    localparam int CMD_DMA     = 15;
    localparam int CMD_DEC_ON  = 12;
    localparam int CMD_DEC_OFF = 13;
    localparam int CMD_CLEAR   = 8;

    localparam int    TIMER_PRESCALE = 3;       // Timer compares counter bits 18..3
    localparam word_t TCNT_RESET     = 16'd55;  // Roughly a 10 ms period

endpackage

// File: host_bus_if.sv
`timescale 1ns/1ps

module host_bus_if (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [vmpeg_pkg::ADDR_W-1:0]    address,
    input  vmpeg_pkg::word_t                din,
    input  logic                            uds,
    input  logic                            lds,
    input  logic                            write_strobe,
    input  logic                            cs,
    input  logic                            ack,
    input  logic                            dtc,
    input  logic                            done_in,
    output logic                            bus_ack,
    output logic                            req,
    output logic                            rdy,
    output logic                            word_valid,
    output logic                            fma_owns_dma,
    output logic [vmpeg_pkg::NUM_CHAN-1:0]  ier_we,
    output logic [vmpeg_pkg::NUM_CHAN-1:0]  ivec_we,
    output logic [vmpeg_pkg::NUM_CHAN-1:0]  isr_rd,
    output logic                            dclkh_rd,
    output logic                            tcnt_we,
    output logic                            trld_we,
    output vmpeg_pkg::word_t                fma_cmd,
    output logic                            fmv_decoder_enable
);
    logic access;
    logic wr_done;
    logic rd_done;
    logic cmd_we;
    logic syscmd_we;
    logic dma_active;

    assign access  = cs && (uds || lds);
    assign wr_done = access && bus_ack && write_strobe;
    assign rd_done = access && bus_ack && !write_strobe;

    assign cmd_we    = wr_done && (address == vmpeg_pkg::REG_FMA_CMD);
    assign syscmd_we = wr_done && (address == vmpeg_pkg::REG_FMV_SYSCMD);

    // Per register strobes, valid in the completing cycle only
    assign ier_we[vmpeg_pkg::CHAN_FMA]  = wr_done && (address == vmpeg_pkg::REG_FMA_IER);
    assign ier_we[vmpeg_pkg::CHAN_FMV]  = wr_done && (address == vmpeg_pkg::REG_FMV_IER);
    assign ivec_we[vmpeg_pkg::CHAN_FMA] = wr_done && (address == vmpeg_pkg::REG_FMA_IVEC);
    assign ivec_we[vmpeg_pkg::CHAN_FMV] = wr_done && (address == vmpeg_pkg::REG_FMV_IVEC);
    assign isr_rd[vmpeg_pkg::CHAN_FMA]  = rd_done && (address == vmpeg_pkg::REG_FMA_ISR);
    assign isr_rd[vmpeg_pkg::CHAN_FMV]  = rd_done && (address == vmpeg_pkg::REG_FMV_ISR);
    assign dclkh_rd = rd_done && (address == vmpeg_pkg::REG_FMA_DCLKH);
    assign tcnt_we  = wr_done && (address == vmpeg_pkg::REG_FMV_TCNT);
    assign trld_we  = wr_done && (address == vmpeg_pkg::REG_FMV_TRLD);

    // Stream words come from DMA or from the XFER register
    assign word_valid = (dma_active && ack && dtc) ||
                        (wr_done && (address == vmpeg_pkg::REG_FMV_XFER));

    assign req = dma_active;
    assign rdy = dma_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= access && !bus_ack;   // Toggles while selected
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_active         <= 1'b0;
            fma_owns_dma       <= 1'b0;
            fma_cmd            <= '0;
            fmv_decoder_enable <= 1'b0;
        end else begin
            if (done_in && ack) begin
                dma_active                  <= 1'b0;
                fma_owns_dma                <= 1'b0;
                fma_cmd[vmpeg_pkg::CMD_DMA] <= 1'b0;   // Transfer finished
            end
            if (cmd_we) begin
                fma_cmd <= din;
                if (din[vmpeg_pkg::CMD_DMA]) begin
                    dma_active   <= 1'b1;
                    fma_owns_dma <= 1'b1;
                end
            end
            if (syscmd_we) begin
                if (din[vmpeg_pkg::CMD_DMA]) begin
                    dma_active   <= 1'b1;
                    fma_owns_dma <= 1'b0;
                end
                if (din[vmpeg_pkg::CMD_DEC_OFF] || din[vmpeg_pkg::CMD_CLEAR])
                    fmv_decoder_enable <= 1'b0;
                if (din[vmpeg_pkg::CMD_DEC_ON])
                    fmv_decoder_enable <= 1'b1;   // On wins over off
            end
        end
    end

endmodule

// File: stream_splitter.sv
`timescale 1ns/1ps

module stream_splitter (
    input  logic              clk,
    input  logic              reset,
    input  logic              word_valid,
    input  vmpeg_pkg::word_t  din,
    input  logic              fma_owns_dma,
    output logic [7:0]        stream_byte,
    output logic              stream_valid,
    output vmpeg_pkg::chan_e  stream_chan
);
    logic [7:0] low_q;
    logic       low_valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            low_valid_q <= 1'b0;
        end else begin
            low_valid_q <= word_valid;
        end
    end

    // Low byte waits one cycle
    always_ff @(posedge clk) begin
        if (word_valid)
            low_q <= din[7:0];
    end

    // A pending low byte hides the next high byte
    assign stream_byte  = low_valid_q ? low_q : din[15:8];
    assign stream_valid = low_valid_q || word_valid;
    assign stream_chan  = fma_owns_dma ? vmpeg_pkg::CHAN_FMA : vmpeg_pkg::CHAN_FMV;

endmodule

// File: dclk_timebase.sv
`timescale 1ns/1ps

module dclk_timebase #(
    parameter logic [9:0] DCLK_DIVIDER = 10'd667   // clk cycles per 45 kHz tick
) (
    input  logic              clk,
    input  logic              reset,
    input  vmpeg_pkg::word_t  din,
    input  logic              tcnt_we,
    input  logic              trld_we,
    input  logic              dclkh_rd,
    output logic [31:0]       dclk,
    output vmpeg_pkg::word_t  dclkl_latch,
    output vmpeg_pkg::word_t  tcnt,
    output logic              timer_tick
);
    localparam int TIMER_W = vmpeg_pkg::DATA_W + vmpeg_pkg::TIMER_PRESCALE + 2;

    logic [9:0]         div_cnt;
    logic               dclk_tick;
    logic [TIMER_W-1:0] timer_cnt;
    logic               timer_match;

    assign dclk_tick   = (div_cnt == DCLK_DIVIDER - 10'd1);
    assign timer_match = (timer_cnt[vmpeg_pkg::TIMER_PRESCALE +: vmpeg_pkg::DATA_W] == tcnt);
    assign timer_tick  = dclk_tick && timer_match;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            dclk        <= '0;
            timer_cnt   <= '0;
            tcnt        <= vmpeg_pkg::TCNT_RESET;
            dclkl_latch <= '0;
        end else begin
            if (dclk_tick) begin
                div_cnt <= '0;
                dclk    <= dclk + 32'd1;
            end else begin
                div_cnt <= div_cnt + 10'd1;
            end

            if (trld_we || timer_tick)
                timer_cnt <= '0;   // Reload or period expired
            else if (dclk_tick)
                timer_cnt <= timer_cnt + TIMER_W'(1);

            if (tcnt_we)
                tcnt <= din;
            if (dclkh_rd)
                dclkl_latch <= dclk[15:0];   // Coherent low half for the next read
        end
    end

endmodule

// File: decoder_event_map.sv
`timescale 1ns/1ps

module decoder_event_map (
    input  logic              clk,
    input  logic              reset,
    input  logic              vsync,
    input  logic              ev_seq,
    input  logic              ev_gop,
    input  logic              ev_pic,
    input  logic              ev_video_underflow,
    input  logic              ev_decoding_started,
    input  logic              ev_frame_decoded,
    input  logic              ev_audio_underflow,
    input  logic              timer_tick,
    output vmpeg_pkg::word_t  set_mask [vmpeg_pkg::NUM_CHAN],
    output vmpeg_pkg::word_t  fma_status
);
    logic vsync_q;
    logic vsync_rise;

    assign vsync_rise = vsync && !vsync_q;

    always_comb begin
        set_mask[vmpeg_pkg::CHAN_FMA] = '0;
        set_mask[vmpeg_pkg::CHAN_FMV] = '0;

        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_SEQ]   = ev_seq;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_GOP]   = ev_gop;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_PIC]   = ev_pic;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_EOD]   = ev_video_underflow;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_NDAT]  = ev_video_underflow;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_TIM]   = timer_tick;
        set_mask[vmpeg_pkg::CHAN_FMV][vmpeg_pkg::FMV_VSYNC] = vsync_rise;

        set_mask[vmpeg_pkg::CHAN_FMA][vmpeg_pkg::FMA_DEC]  = ev_decoding_started;
        set_mask[vmpeg_pkg::CHAN_FMA][vmpeg_pkg::FMA_UPD]  = ev_frame_decoded;
        set_mask[vmpeg_pkg::CHAN_FMA][vmpeg_pkg::FMA_UNF]  = ev_audio_underflow;
        set_mask[vmpeg_pkg::CHAN_FMA][vmpeg_pkg::FMA_POLL] = timer_tick;   // Shared timer
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q    <= 1'b0;
            fma_status <= '0;
        end else begin
            vsync_q <= vsync;
            if (ev_decoding_started)
                fma_status[vmpeg_pkg::FMA_DEC] <= 1'b1;
            if (ev_frame_decoded) begin
                fma_status[vmpeg_pkg::FMA_DEC] <= 1'b0;   // Decoding round complete
                fma_status[vmpeg_pkg::FMA_UPD] <= 1'b1;
            end
            if (ev_audio_underflow)
                fma_status[vmpeg_pkg::FMA_UNF] <= 1'b1;
        end
    end

endmodule

// File: irq_channel.sv
`timescale 1ns/1ps

module irq_channel (
    input  logic              clk,
    input  logic              reset,
    input  vmpeg_pkg::word_t  din,
    input  logic              ier_we,
    input  logic              ivec_we,
    input  logic              isr_rd,
    input  vmpeg_pkg::word_t  set_mask,
    output vmpeg_pkg::word_t  isr,
    output vmpeg_pkg::word_t  ier,
    output vmpeg_pkg::word_t  ivec,
    output logic              irq
);
    always_ff @(posedge clk) begin
        if (reset) begin
            isr  <= '0;
            ier  <= '0;
            ivec <= '0;
        end else begin
            isr <= (isr_rd ? '0 : isr) | set_mask;   // New events survive the clear
            if (ier_we)
                ier <= din;
            if (ivec_we)
                ivec <= din;
        end
    end

    assign irq = |(isr & ier);

endmodule

// File: host_read_mux.sv
`timescale 1ns/1ps

module host_read_mux (
    input  logic [vmpeg_pkg::ADDR_W-1:0]    address,
    input  logic                            intack,
    input  logic [vmpeg_pkg::NUM_CHAN-1:0]  irq,
    input  vmpeg_pkg::word_t                isr [vmpeg_pkg::NUM_CHAN],
    input  vmpeg_pkg::word_t                ier [vmpeg_pkg::NUM_CHAN],
    input  vmpeg_pkg::word_t                ivec [vmpeg_pkg::NUM_CHAN],
    input  vmpeg_pkg::word_t                fma_cmd,
    input  vmpeg_pkg::word_t                fma_status,
    input  logic [31:0]                     dclk,
    input  vmpeg_pkg::word_t                dclkl_latch,
    input  vmpeg_pkg::word_t                tcnt,
    output vmpeg_pkg::word_t                dout,
    output logic                            intreq
);
    vmpeg_pkg::word_t reg_data;
    vmpeg_pkg::word_t fma_vec;
    vmpeg_pkg::word_t fmv_vec;

    always_comb begin
        case (address)
            vmpeg_pkg::REG_FMA_CMD:   reg_data = fma_cmd;
            vmpeg_pkg::REG_FMA_STAT:  reg_data = fma_status;
            vmpeg_pkg::REG_FMA_IVEC:  reg_data = ivec[vmpeg_pkg::CHAN_FMA];
            vmpeg_pkg::REG_FMA_DCLKH: reg_data = dclk[31:16];
            vmpeg_pkg::REG_FMA_DCLKL: reg_data = dclkl_latch;   // Latched by the DCLKH read
            vmpeg_pkg::REG_FMA_ISR:   reg_data = isr[vmpeg_pkg::CHAN_FMA];
            vmpeg_pkg::REG_FMA_IER:   reg_data = ier[vmpeg_pkg::CHAN_FMA];
            vmpeg_pkg::REG_FMV_IER:   reg_data = ier[vmpeg_pkg::CHAN_FMV];
            vmpeg_pkg::REG_FMV_ISR:   reg_data = isr[vmpeg_pkg::CHAN_FMV];
            vmpeg_pkg::REG_FMV_TCNT:  reg_data = tcnt;
            vmpeg_pkg::REG_FMV_IVEC:  reg_data = ivec[vmpeg_pkg::CHAN_FMV];
            default:                  reg_data = '0;   // Write-only and unmapped
        endcase
    end

    // Vector byte repeated on both lanes
    assign fma_vec = {ivec[vmpeg_pkg::CHAN_FMA][7:0], ivec[vmpeg_pkg::CHAN_FMA][7:0]};
    assign fmv_vec = {ivec[vmpeg_pkg::CHAN_FMV][10:3], ivec[vmpeg_pkg::CHAN_FMV][10:3]};

    always_comb begin
        if (intack)
            dout = irq[vmpeg_pkg::CHAN_FMA] ? fma_vec : fmv_vec;   // FMA has priority
        else
            dout = reg_data;
    end

    assign intreq = |irq;

endmodule

// File: vmpeg_top.sv
`timescale 1ns/1ps

module vmpeg_top #(
    parameter logic [9:0] DCLK_DIVIDER = 10'd667
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [vmpeg_pkg::ADDR_W-1:0]  address,
    input  vmpeg_pkg::word_t              din,
    output vmpeg_pkg::word_t              dout,
    input  logic                          uds,
    input  logic                          lds,
    input  logic                          write_strobe,
    input  logic                          cs,
    output logic                          bus_ack,
    output logic                          intreq,
    input  logic                          intack,
    output logic                          req,
    input  logic                          ack,
    output logic                          rdy,
    input  logic                          dtc,
    input  logic                          done_in,
    input  logic                          vsync,
    input  logic                          ev_seq,
    input  logic                          ev_gop,
    input  logic                          ev_pic,
    input  logic                          ev_video_underflow,
    input  logic                          ev_decoding_started,
    input  logic                          ev_frame_decoded,
    input  logic                          ev_audio_underflow,
    output logic [7:0]                    stream_byte,
    output logic                          stream_valid,
    output vmpeg_pkg::chan_e              stream_chan,
    output logic                          fmv_decoder_enable
);
    logic                           word_valid;
    logic                           fma_owns_dma;
    logic [vmpeg_pkg::NUM_CHAN-1:0] ier_we;
    logic [vmpeg_pkg::NUM_CHAN-1:0] ivec_we;
    logic [vmpeg_pkg::NUM_CHAN-1:0] isr_rd;
    logic                           dclkh_rd;
    logic                           tcnt_we;
    logic                           trld_we;
    logic                           timer_tick;
    logic [vmpeg_pkg::NUM_CHAN-1:0] irq;
    logic [31:0]                    dclk;
    vmpeg_pkg::word_t               fma_cmd;
    vmpeg_pkg::word_t               fma_status;
    vmpeg_pkg::word_t               dclkl_latch;
    vmpeg_pkg::word_t               tcnt;
    vmpeg_pkg::word_t               set_mask [vmpeg_pkg::NUM_CHAN];
    vmpeg_pkg::word_t               isr [vmpeg_pkg::NUM_CHAN];
    vmpeg_pkg::word_t               ier [vmpeg_pkg::NUM_CHAN];
    vmpeg_pkg::word_t               ivec [vmpeg_pkg::NUM_CHAN];

    host_bus_if u_bus (
        .clk, .reset, .address, .din, .uds, .lds, .write_strobe, .cs, .ack, .dtc, .done_in,
        .bus_ack, .req, .rdy, .word_valid, .fma_owns_dma, .ier_we, .ivec_we, .isr_rd,
        .dclkh_rd, .tcnt_we, .trld_we, .fma_cmd, .fmv_decoder_enable
    );

    stream_splitter u_split (
        .clk, .reset, .word_valid, .din, .fma_owns_dma,
        .stream_byte, .stream_valid, .stream_chan
    );

    dclk_timebase #(
        .DCLK_DIVIDER(DCLK_DIVIDER)
    ) u_timebase (
        .clk, .reset, .din, .tcnt_we, .trld_we, .dclkh_rd,
        .dclk, .dclkl_latch, .tcnt, .timer_tick
    );

    decoder_event_map u_events (
        .clk, .reset, .vsync, .ev_seq, .ev_gop, .ev_pic, .ev_video_underflow,
        .ev_decoding_started, .ev_frame_decoded, .ev_audio_underflow, .timer_tick,
        .set_mask, .fma_status
    );

    // Index 0 is FMA, index 1 is FMV
    for (genvar i = 0; i < vmpeg_pkg::NUM_CHAN; i++) begin : g_chan
        irq_channel u_irq (
            .clk      (clk),
            .reset    (reset),
            .din      (din),
            .ier_we   (ier_we[i]),
            .ivec_we  (ivec_we[i]),
            .isr_rd   (isr_rd[i]),
            .set_mask (set_mask[i]),
            .isr      (isr[i]),
            .ier      (ier[i]),
            .ivec     (ivec[i]),
            .irq      (irq[i])
        );
    end

    host_read_mux u_rdmux (
        .address, .intack, .irq, .isr, .ier, .ivec, .fma_cmd, .fma_status,
        .dclk, .dclkl_latch, .tcnt, .dout, .intreq
    );

endmodule

// File: vmpeg_assert.sv
`timescale 1ns/1ps

module vmpeg_assert (
    input logic             clk,
    input logic             reset,
    input logic             cs,
    input logic             uds,
    input logic             lds,
    input logic             write_strobe,
    input logic             ack,
    input logic             done_in,
    input logic             bus_ack,
    input logic             req,
    input logic             rdy,
    input logic             intreq,
    input vmpeg_pkg::word_t fma_ier,
    input vmpeg_pkg::word_t fmv_ier
);
    // DMA request rises only after a completed bus write
    a_req_rdy: assert property (@(posedge clk) disable iff (reset)
        (req == rdy) && (!$rose(req) || $past(cs && bus_ack && write_strobe)))
        else $error("req and rdy differ or req rose without a bus write");

    a_req_done: assert property (@(posedge clk) disable iff (reset)
        $fell(req) |-> $past(done_in && ack))
        else $error("req fell without done_in and ack");

    // Acknowledge only during an access
    a_ack_idle: assert property (@(posedge clk) disable iff (reset)
        !(cs && (uds || lds)) |-> !bus_ack)
        else $error("bus_ack high without access");

    a_irq_masked: assert property (@(posedge clk) disable iff (reset)
        (fma_ier == '0 && fmv_ier == '0) |-> !intreq)
        else $error("intreq high with all enables clear");

endmodule

bind vmpeg_top vmpeg_assert u_assert (
    .clk, .reset, .cs, .uds, .lds, .write_strobe, .ack, .done_in,
    .bus_ack, .req, .rdy, .intreq,
    .fma_ier (ier[0]),
    .fmv_ier (ier[1])
);

// File: tb_vmpeg.sv
`timescale 1ns/1ps

module tb_vmpeg;

    localparam int TABLE_LEN = 14;
    localparam int CLK_NS    = 4;

    typedef enum logic {OP_WR, OP_RD} op_e;

    typedef struct packed {
        op_e              op;
        logic [14:0]      addr;
        vmpeg_pkg::word_t data;
        vmpeg_pkg::word_t expect_val;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic [14:0]            address;
    vmpeg_pkg::word_t       din;
    vmpeg_pkg::word_t       dout;
    logic                   uds;
    logic                   lds;
    logic                   write_strobe;
    logic                   cs;
    logic                   bus_ack;
    logic                   intreq;
    logic                   intack;
    logic                   req;
    logic                   ack;
    logic                   rdy;
    logic                   dtc;
    logic                   done_in;
    logic                   vsync;
    logic                   ev_seq;
    logic                   ev_gop;
    logic                   ev_pic;
    logic                   ev_video_underflow;
    logic                   ev_decoding_started;
    logic                   ev_frame_decoded;
    logic                   ev_audio_underflow;
    logic [7:0]             stream_byte;
    logic                   stream_valid;
    vmpeg_pkg::chan_e       stream_chan;
    logic                   fmv_decoder_enable;

    entry_t                 tbl [TABLE_LEN];
    int                     errors = 0;
    logic [15:0]            lfsr_state = 16'd17876;
    logic [8:0]             exp_bytes [$];   // {chan, byte}
    logic [8:0]             got_bytes [$];

    vmpeg_top #(.DCLK_DIVIDER(10'd4)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic vmpeg_pkg::word_t random_word();
        vmpeg_pkg::word_t w;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};   // One step per bit
        end
        return w;
    endfunction

    task automatic check_word(input vmpeg_pkg::word_t exp_v, input vmpeg_pkg::word_t act,
                              input string name);
        if (act !== exp_v) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_v, act);
            errors++;
        end
    endtask

    task automatic check_bit(input logic exp_v, input logic act, input string name);
        if (act !== exp_v) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp_v, act);
            errors++;
        end
    endtask

    // Holds cs until the toggling acknowledge completes the cycle
    task automatic bus_cycle(input logic wr, input logic [14:0] addr,
                             input vmpeg_pkg::word_t data, output vmpeg_pkg::word_t rd);
        int n;
        @(negedge clk);
        address      = addr;
        din          = data;
        write_strobe = wr;
        cs           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        n            = 0;
        @(negedge clk);
        while (!bus_ack && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!bus_ack) begin
            $display("Bus cycle to address %h was never acknowledged", addr);
            errors++;
        end
        rd = dout;
        @(negedge clk);
        cs           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input logic [14:0] addr, input vmpeg_pkg::word_t data);
        vmpeg_pkg::word_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [14:0] addr, output vmpeg_pkg::word_t rd);
        bus_cycle(1'b0, addr, 16'h0000, rd);
    endtask

    // One cycle pulse on decoder event idx
    task automatic pulse_event(input int idx);
        @(negedge clk);
        case (idx)
            0: ev_seq = 1'b1;
            1: ev_gop = 1'b1;
            2: ev_pic = 1'b1;
            3: ev_video_underflow = 1'b1;
            4: vsync = 1'b1;
            5: ev_decoding_started = 1'b1;
            6: ev_frame_decoded = 1'b1;
            default: ev_audio_underflow = 1'b1;
        endcase
        @(negedge clk);
        {ev_seq, ev_gop, ev_pic, ev_video_underflow, vsync} = '0;
        {ev_decoding_started, ev_frame_decoded, ev_audio_underflow} = '0;
    endtask

    task automatic dma_word(input vmpeg_pkg::word_t w, input logic chan);
        din = w;
        ack = 1'b1;
        dtc = 1'b1;
        exp_bytes.push_back({chan, w[15:8]});
        exp_bytes.push_back({chan, w[7:0]});
        @(negedge clk);
        ack = 1'b0;
        dtc = 1'b0;
        @(negedge clk);
        @(negedge clk);   // Gap so no high byte is lost
    endtask

    task automatic dma_done();
        @(negedge clk);
        done_in = 1'b1;
        ack     = 1'b1;
        @(negedge clk);
        done_in = 1'b0;
        ack     = 1'b0;
        check_bit(1'b0, req, "req");
        check_bit(1'b0, rdy, "rdy");
    endtask

    // Stream capture, sampled after inputs settle
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (stream_valid)
                got_bytes.push_back({stream_chan, stream_byte});
        end
    end

    initial begin
        #(TABLE_LEN * 200 * CLK_NS);
        $display("Run timed out after %0d cycles", TABLE_LEN * 200);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        vmpeg_pkg::word_t rd;
        vmpeg_pkg::word_t mask;
        vmpeg_pkg::word_t stat_exp;
        vmpeg_pkg::word_t fma_ivec;
        vmpeg_pkg::word_t fmv_ivec;
        logic [14:0]      ier_addr;
        logic [14:0]      isr_addr;
        logic [31:0]      dclk_a;
        logic [31:0]      dclk_b;
        int               n;

        reset = 1'b1;
        {address, din, uds, lds, write_strobe, cs, intack, ack, dtc, done_in} = '0;
        {vsync, ev_seq, ev_gop, ev_pic, ev_video_underflow} = '0;
        {ev_decoding_started, ev_frame_decoded, ev_audio_underflow} = '0;
        fma_ivec = 16'h0042;
        fmv_ivec = 16'h0318;

        tbl[0]  = '{OP_RD, 15'h2032, 16'h0000, 16'd55};   // TCNT reset value
        tbl[1]  = '{OP_WR, 15'h180E, 16'hA5A5, 16'h0000};
        tbl[2]  = '{OP_RD, 15'h180E, 16'h0000, 16'hA5A5};
        tbl[3]  = '{OP_WR, 15'h2030, 16'h0F0F, 16'h0000};
        tbl[4]  = '{OP_RD, 15'h2030, 16'h0000, 16'h0F0F};
        tbl[5]  = '{OP_WR, 15'h1806, fma_ivec, 16'h0000};
        tbl[6]  = '{OP_RD, 15'h1806, 16'h0000, fma_ivec};
        tbl[7]  = '{OP_WR, 15'h206E, fmv_ivec, 16'h0000};
        tbl[8]  = '{OP_RD, 15'h206E, 16'h0000, fmv_ivec};
        tbl[9]  = '{OP_WR, 15'h2032, 16'h1234, 16'h0000};
        tbl[10] = '{OP_RD, 15'h2032, 16'h0000, 16'h1234};
        tbl[11] = '{OP_RD, 15'h1802, 16'h0000, 16'h0000};  // Unmapped
        tbl[12] = '{OP_WR, 15'h180E, 16'h0000, 16'h0000};
        tbl[13] = '{OP_WR, 15'h2030, 16'h0000, 16'h0000};

        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Outputs idle out of reset
        check_bit(1'b0, bus_ack, "bus_ack");
        check_bit(1'b0, req, "req");
        check_bit(1'b0, rdy, "rdy");
        check_bit(1'b0, intreq, "intreq");
        check_bit(1'b0, stream_valid, "stream_valid");
        check_bit(1'b0, fmv_decoder_enable, "fmv_decoder_enable");

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (tbl[i].op == OP_WR) begin
                bus_write(tbl[i].addr, tbl[i].data);
            end else begin
                bus_read(tbl[i].addr, rd);
                check_word(tbl[i].expect_val, rd, $sformatf("dout @%h", tbl[i].addr));
            end
        end

        // Event mapping and read-clear
        stat_exp = '0;
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: mask = 16'h0001 << vmpeg_pkg::FMV_SEQ;
                1: mask = 16'h0001 << vmpeg_pkg::FMV_GOP;
                2: mask = 16'h0001 << vmpeg_pkg::FMV_PIC;
                3: mask = (16'h0001 << vmpeg_pkg::FMV_EOD) | (16'h0001 << vmpeg_pkg::FMV_NDAT);
                4: mask = 16'h0001 << vmpeg_pkg::FMV_VSYNC;
                5: mask = 16'h0001 << vmpeg_pkg::FMA_DEC;
                6: mask = 16'h0001 << vmpeg_pkg::FMA_UPD;
                default: mask = 16'h0001 << vmpeg_pkg::FMA_UNF;
            endcase
            ier_addr = (i < 5) ? 15'h2030 : 15'h180E;
            isr_addr = (i < 5) ? 15'h2031 : 15'h180D;
            pulse_event(i);
            bus_write(ier_addr, random_word() | mask);
            check_bit(1'b1, intreq, "intreq");
            bus_read(isr_addr, rd);
            check_word(mask, rd, "isr");
            bus_read(isr_addr, rd);
            check_word(16'h0000, rd, "isr after clear");
            check_bit(1'b0, intreq, "intreq");
            bus_write(ier_addr, 16'h0000);
            if (i >= 5) begin
                if (i == 5)
                    stat_exp[vmpeg_pkg::FMA_DEC] = 1'b1;
                if (i == 6) begin
                    stat_exp[vmpeg_pkg::FMA_DEC] = 1'b0;
                    stat_exp[vmpeg_pkg::FMA_UPD] = 1'b1;
                end
                if (i == 7)
                    stat_exp[vmpeg_pkg::FMA_UNF] = 1'b1;
                bus_read(15'h1801, rd);
                check_word(stat_exp, rd, "fma stat");
            end
        end

        // Vector on acknowledge, FMA first
        bus_write(15'h180E, 16'hFFFF);
        bus_write(15'h2030, 16'hFFFF);
        @(negedge clk);
        ev_seq             = 1'b1;
        ev_audio_underflow = 1'b1;
        @(negedge clk);
        ev_seq             = 1'b0;
        ev_audio_underflow = 1'b0;
        @(negedge clk);
        intack = 1'b1;
        #1;
        check_word(16'h4242, dout, "dout vector");   // FMA vector 0x0042, low byte twice
        @(negedge clk);
        intack = 1'b0;
        bus_read(15'h180D, rd);
        intack = 1'b1;
        #1;
        check_word(16'h6363, dout, "dout vector");   // FMV vector 0x0318, bits 10..3 twice
        @(negedge clk);
        intack = 1'b0;
        bus_read(15'h2031, rd);
        bus_write(15'h180E, 16'h0000);
        bus_write(15'h2030, 16'h0000);

        // DMA and stream bytes
        bus_write(15'h2060, 16'h8000);
        check_bit(1'b1, req, "req");
        check_bit(1'b1, rdy, "rdy");
        for (int i = 0; i < 4; i++)
            dma_word(random_word(), vmpeg_pkg::CHAN_FMV);
        mask = random_word();
        exp_bytes.push_back({vmpeg_pkg::CHAN_FMV, mask[15:8]});
        exp_bytes.push_back({vmpeg_pkg::CHAN_FMV, mask[7:0]});
        bus_write(15'h206F, mask);
        dma_done();
        bus_write(15'h1800, 16'h8000);
        check_bit(1'b1, req, "req");
        dma_word(random_word(), vmpeg_pkg::CHAN_FMA);
        dma_done();
        @(negedge clk);
        if (got_bytes.size() != exp_bytes.size()) begin
            $display("Stream carried %0d bytes where %0d were expected",
                     got_bytes.size(), exp_bytes.size());
            errors++;
        end else begin
            foreach (exp_bytes[i]) begin
                check_word({8'h00, exp_bytes[i][7:0]}, {8'h00, got_bytes[i][7:0]},
                           "stream_byte");
                check_bit(exp_bytes[i][8], got_bytes[i][8], "stream_chan");
            end
        end

        // Timer with compare at 1
        bus_write(15'h2032, 16'h0001);
        bus_read(15'h2031, rd);
        bus_read(15'h180D, rd);
        bus_write(15'h2030, 16'h0001 << vmpeg_pkg::FMV_TIM);
        bus_write(15'h2057, 16'h0000);
        n = 0;
        while (!intreq && n < 40) begin
            @(negedge clk);
            n++;
        end
        check_bit(1'b1, intreq, "intreq timer");
        bus_read(15'h2031, rd);
        check_word(16'h0001 << vmpeg_pkg::FMV_TIM, rd, "fmv isr timer");
        bus_read(15'h180D, rd);
        check_word(16'h0001 << vmpeg_pkg::FMA_POLL, rd, "fma isr poll");
        bus_write(15'h2032, 16'h1234);
        bus_write(15'h2030, 16'h0000);

        // Samples six cycles apart span at least one DCLK tick
        bus_read(15'h1808, rd);
        dclk_a[31:16] = rd;
        bus_read(15'h1809, rd);
        dclk_a[15:0] = rd;
        bus_read(15'h1808, rd);
        dclk_b[31:16] = rd;
        bus_read(15'h1809, rd);
        dclk_b[15:0] = rd;
        check_bit(1'b1, dclk_b > dclk_a, "dclk advancing");

        // Decoder enable level
        bus_write(15'h2060, 16'h1000);
        check_bit(1'b1, fmv_decoder_enable, "fmv_decoder_enable");
        bus_write(15'h2060, 16'h2000);
        check_bit(1'b0, fmv_decoder_enable, "fmv_decoder_enable");
        bus_write(15'h2060, 16'h1000);
        check_bit(1'b1, fmv_decoder_enable, "fmv_decoder_enable");
        bus_write(15'h2060, 16'h0100);
        check_bit(1'b0, fmv_decoder_enable, "fmv_decoder_enable");

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: vmpeg_top.f
vmpeg_pkg.sv
host_bus_if.sv
stream_splitter.sv
dclk_timebase.sv
decoder_event_map.sv
irq_channel.sv
host_read_mux.sv
vmpeg_top.sv
vmpeg_assert.sv
tb_vmpeg.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f vmpeg_top.f --top-module tb_vmpeg -Mdir obj_dir -o tb_vmpeg

run: compile
	./obj_dir/tb_vmpeg | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
